//--- riscv_v_alu.f
+incdir+include
hw/riscv_v_pkg.sv
hw/riscv_v_alu_if.sv
hw/riscv_v_decode.sv
hw/shifter.sv
hw/riscv_v_shifter.sv
hw/riscv_v_int_unit.sv
hw/riscv_v_result_sel.sv
hw/riscv_v_alu.sv
verif/riscv_v_alu_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the vector ALU testbench with Verilator and run it.
# The exit status of the simulation binary is the test result.
set -e

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal \
    -f riscv_v_alu.f \
    --top-module riscv_v_alu_tb \
    -o riscv_v_alu_sim

./obj_dir/riscv_v_alu_sim

//--- include/riscv_v_alu_model.svh
/*
 * Vector ALU reference model
 * Expected result per element and for a whole 64-bit slice
 */
`ifndef RISCV_V_ALU_MODEL_SVH
`define RISCV_V_ALU_MODEL_SVH

// One element, right-aligned in a 64-bit word
function automatic logic [63:0] model_elem(input riscv_v_alu_op_t op,
                                           input logic [63:0]     a,
                                           input logic [63:0]     b,
                                           input int unsigned     ew);
    logic [63:0] mask;
    logic [63:0] sb;
    logic [5:0]  cnt;
    logic [63:0] r;

    mask = (ew == 64) ? {64{1'b1}} : ((64'd1 << ew) - 64'd1);
    cnt  = a[5:0] & 6'(ew - 1);
    // Sign-extended copy for vsra
    sb   = b[ew-1] ? (b | ~mask) : (b & mask);
    case (op)
        VADD:    r = a + b;
        VSUB:    r = a - b;
        VAND:    r = a & b;
        VOR:     r = a | b;
        VXOR:    r = a ^ b;
        VSLL:    r = b << cnt;
        VSRL:    r = (b & mask) >> cnt;
        default: r = 64'($signed(sb) >>> cnt);
    endcase
    return r & mask;
endfunction

// Whole slice, element by element
function automatic logic [63:0] riscv_v_alu_model(input riscv_v_alu_op_t op,
                                                  input osize_t          osize,
                                                  input logic [63:0]     a,
                                                  input logic [63:0]     b);
    int unsigned ew;
    int unsigned n;
    logic [63:0] mask;
    logic [63:0] res;

    ew   = 8 << osize;
    n    = 64 / ew;
    mask = (ew == 64) ? {64{1'b1}} : ((64'd1 << ew) - 64'd1);
    res  = '0;
    for (int e = 0; e < n; e++) begin
        res |= model_elem(op, (a >> (e * ew)) & mask, (b >> (e * ew)) & mask, ew) << (e * ew);
    end
    return res;
endfunction

`endif

//--- verif/riscv_v_alu_tb.sv
/*
 * Vector ALU testbench
 * Directed and LFSR-driven operations, reference-model pipeline,
 * result and valid checks
 */
`timescale 1ns/1ps

module riscv_v_alu_tb
    import riscv_v_pkg::*;
;

    `include "riscv_v_alu_model.svh"

    localparam int          CLK_PERIOD   = 4;
    localparam int          RESET_CYCLES = 3;
    localparam int          NUM_OPS      = 600;
    localparam int          WATCHDOG_NS  = RESET_CYCLES * CLK_PERIOD
                                         + (NUM_OPS * CLK_PERIOD * 3) / 2;
    localparam logic [31:0] LFSR_SEED    = 32'h6def_be9b;
    localparam logic [31:0] LFSR_TAPS    = 32'h8020_0003;
    // Negative bytes, halves, words and a negative 64-bit element
    localparam logic [63:0] SHIFT_DATA   = 64'h80F1_7F02_C3A5_81FF;

    logic                          clk = 1'b0;
    logic                          rst_n;
    logic                          in_valid;
    riscv_v_alu_op_t               op;
    osize_t                        osize;
    logic [RISCV_V_DATA_WIDTH-1:0] srca;
    logic [RISCV_V_DATA_WIDTH-1:0] srcb;
    logic                          out_valid;
    logic [RISCV_V_DATA_WIDTH-1:0] result;

    logic [31:0] lfsr_state = LFSR_SEED;
    logic [1:0]  exp_valid  = '0;
    logic [63:0] exp_result [2];
    logic        ck_armed   = 1'b0;
    int          ops_sent   = 0;
    int          checked    = 0;

    riscv_v_alu UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .op        (op),
        .osize     (osize),
        .srca      (srca),
        .srcb      (srcb),
        .out_valid (out_valid),
        .result    (result)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    // One LFSR step per bit
    task automatic take_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v          = {v[62:0], lfsr_state[0]};
        end
    endtask

    task automatic drive_op(input riscv_v_alu_op_t o, input osize_t s,
                            input logic [63:0] a, input logic [63:0] b);
        @(negedge clk);
        in_valid = 1'b1;
        op       = o;
        osize    = s;
        srca     = a;
        srcb     = b;
        ops_sent++;
    endtask

    task automatic idle_cycle();
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    // Expected results travel two stages, like decode and result registers
    always @(posedge clk) begin
        ck_armed <= 1'b1;
        if (!rst_n) begin
            exp_valid     <= '0;
            exp_result[0] <= '0;
            exp_result[1] <= '0;
        end else begin
            exp_valid     <= {exp_valid[0], in_valid};
            exp_result[1] <= exp_result[0];
            if (in_valid) begin
                exp_result[0] <= riscv_v_alu_model(op, osize, srca, srcb);
            end
            if (exp_valid[1]) begin
                checked <= checked + 1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!ck_armed) out_valid == exp_valid[1])
        else begin
            $display("out_valid did not follow in_valid two cycles later (expected %0b)",
                     $sampled(exp_valid[1]));
            $display("Test failed");
            $fatal(1, "out_valid check");
        end

    assert property (@(posedge clk) disable iff (!ck_armed)
        exp_valid[1] |-> result == exp_result[1])
        else begin
            $display("MISMATCH result expected %h actual %h",
                     $sampled(exp_result[1]), $sampled(result));
            $display("Test failed");
            $fatal(1, "result check");
        end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before all operations completed");
        $display("Test failed");
        $fatal(1, "timeout");
    end

    initial begin
        int unsigned     ew;
        logic [7:0]      cnt_byte;
        logic [63:0]     bits;
        logic [63:0]     a;
        logic [63:0]     b;
        riscv_v_alu_op_t r_op;
        osize_t          r_osize;

        rst_n    = 1'b0;
        in_valid = 1'b0;
        op       = VADD;
        osize    = OSIZE_8;
        srca     = '0;
        srcb     = '0;

        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        idle_cycle();

        // Carry and borrow at element edges, shift counts 0 and width-1
        for (int sz = 0; sz < RISCV_V_NUM_VALID_OSIZES; sz++) begin
            ew = 8 << sz;
            drive_op(VADD, osize_t'(sz), '1, '1);
            drive_op(VADD, osize_t'(sz), '1, 64'd1);
            drive_op(VSUB, osize_t'(sz), '0, 64'd1);
            for (int c = 0; c < 2; c++) begin
                cnt_byte = (c == 0) ? 8'd0 : 8'(ew - 1);
                drive_op(VSLL, osize_t'(sz), {8{cnt_byte}}, SHIFT_DATA);
                drive_op(VSRL, osize_t'(sz), {8{cnt_byte}}, SHIFT_DATA);
                drive_op(VSRA, osize_t'(sz), {8{cnt_byte}}, SHIFT_DATA);
            end
        end

        // Random traffic with occasional gaps
        while (ops_sent < NUM_OPS) begin
            take_bits(3, bits);
            if (bits[2:0] == 3'd0) begin
                idle_cycle();
            end else begin
                take_bits(3, bits);
                r_op = riscv_v_alu_op_t'(bits[2:0]);
                take_bits(2, bits);
                r_osize = osize_t'(bits[1:0]);
                take_bits(64, a);
                take_bits(64, b);
                drive_op(r_op, r_osize, a, b);
            end
        end

        idle_cycle();
        repeat (4) @(negedge clk);

        if (checked == NUM_OPS) begin
            $display("Test passed");
            $finish;
        end else begin
            $display("Only %0d of %0d results were checked", checked, NUM_OPS);
            $display("Test failed");
            $fatal(1, "result count");
        end
    end

endmodule : riscv_v_alu_tb

//--- hw/riscv_v_alu.sv
/*
 * Vector integer ALU slice
 * Decode, shifter and integer unit side by side, registered result
 */
`timescale 1ns/1ps

module riscv_v_alu
    import riscv_v_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          in_valid,
    input  riscv_v_alu_op_t               op,
    input  osize_t                        osize,
    input  logic [RISCV_V_DATA_WIDTH-1:0] srca,
    input  logic [RISCV_V_DATA_WIDTH-1:0] srcb,
    output logic                          out_valid,
    output logic [RISCV_V_DATA_WIDTH-1:0] result
);

    riscv_v_alu_if alu_if ();

    logic [RISCV_V_DATA_WIDTH-1:0] shift_result;
    logic [RISCV_V_DATA_WIDTH-1:0] int_result;

    riscv_v_decode u_decode (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .op       (op),
        .osize    (osize),
        .srca     (srca),
        .srcb     (srcb),
        .alu_if   (alu_if)
    );

    riscv_v_shifter u_shifter (
        .alu_if (alu_if),
        .result (shift_result)
    );

    riscv_v_int_unit u_int_unit (
        .alu_if (alu_if),
        .result (int_result)
    );

    riscv_v_result_sel u_result_sel (
        .clk          (clk),
        .rst_n        (rst_n),
        .shift_result (shift_result),
        .int_result   (int_result),
        .alu_if       (alu_if),
        .out_valid    (out_valid),
        .result       (result)
    );

endmodule : riscv_v_alu

//--- hw/riscv_v_result_sel.sv
/*
 * Vector ALU result stage
 * Picks the shifter or integer-unit output and registers it
 */
`timescale 1ns/1ps

module riscv_v_result_sel
    import riscv_v_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [RISCV_V_DATA_WIDTH-1:0] shift_result,
    input  logic [RISCV_V_DATA_WIDTH-1:0] int_result,
    riscv_v_alu_if.sel                    alu_if,
    output logic                          out_valid,
    output logic [RISCV_V_DATA_WIDTH-1:0] result
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            result    <= '0;
        end else begin
            out_valid <= alu_if.valid;
            // Hold the last result through gaps
            if (alu_if.valid) begin
                result <= alu_if.is_shift ? shift_result : int_result;
            end
        end
    end

    // Decode and result stage both come out of reset empty
    assert property (@(posedge clk) $rose(rst_n) |-> !out_valid ##1 !out_valid)
        else $error("result_sel: out_valid high right after reset release");

endmodule : riscv_v_result_sel

//--- hw/riscv_v_int_unit.sv
/*
 * Vector integer unit
 * Byte-lane add and subtract with the carry cut at element edges,
 * plus bitwise logic
 */
`timescale 1ns/1ps

module riscv_v_int_unit
    import riscv_v_pkg::*;
(
    riscv_v_alu_if.intu                   alu_if,
    output logic [RISCV_V_DATA_WIDTH-1:0] result
);

    logic                          is_sub;
    riscv_v_src_byte_vector_t      add_result;
    logic [RISCV_V_DATA_WIDTH-1:0] opa;
    logic [RISCV_V_DATA_WIDTH-1:0] opb;

    assign is_sub = (alu_if.op == VSUB);
    assign opa    = alu_if.srca.data;
    assign opb    = alu_if.srcb.data;

    // Subtract as a + ~b + 1 per element
    always_comb begin
        logic                carry;
        logic [BYTE_WIDTH:0] lane_sum;
        Byte_t               addend;

        carry = is_sub;
        for (int i = 0; i < RISCV_V_NUM_BYTES_DATA; i++) begin
            addend        = is_sub ? ~alu_if.srcb.data[i] : alu_if.srcb.data[i];
            lane_sum      = {1'b0, alu_if.srca.data[i]} + {1'b0, addend}
                          + {{BYTE_WIDTH{1'b0}}, carry};
            add_result[i] = lane_sum[BYTE_WIDTH-1:0];
            // Next element base restarts with the subtract carry
            carry         = alu_if.srcb.merge[i] ? lane_sum[BYTE_WIDTH] : is_sub;
        end
    end

    always_comb begin
        case (alu_if.op)
            VAND:    result = opa & opb;
            VOR:     result = opa | opb;
            VXOR:    result = opa ^ opb;
            default: result = add_result;
        endcase
    end

endmodule : riscv_v_int_unit

//--- hw/riscv_v_shifter.sv
/*
 * Vector barrel shifter
 * Byte-lane mux network for whole-byte moves followed by per-lane
 * bit shifters, kept inside element boundaries
 */
`timescale 1ns/1ps

module riscv_v_shifter
    import riscv_v_pkg::*;
(
    riscv_v_alu_if.shift              alu_if,
    output riscv_v_src_byte_vector_t  result
);

    riscv_v_shift_cnt_t       cnt_mask;
    riscv_v_shift_cnt_t       shift_cnt [RISCV_V_NUM_BYTES_DATA];
    riscv_v_shift_cnt_t       lane_cnt [RISCV_V_NUM_BYTES_DATA];
    riscv_v_src_byte_vector_t data_in;
    riscv_v_merge_data_t      lane_merge;
    Byte_t                    byte_mux [RISCV_V_BYTE_SEL_WIDTH+1][RISCV_V_NUM_BYTES_DATA];
    riscv_v_src_byte_vector_t lane_shift_in;
    logic [RISCV_V_NUM_BYTES_DATA-1:0] lane_arith;
    riscv_v_src_byte_vector_t lane_result;

    // Count bits above the element width are dropped
    assign cnt_mask = {alu_if.is_greater_osize_vector[RISCV_V_NUM_VALID_OSIZES-1:1],
                       {RISCV_V_BIT_SEL_WIDTH{1'b1}}};

    // Each lane takes the count from the base byte of its element
    always_comb begin
        for (int i = 0; i < RISCV_V_NUM_BYTES_DATA; i++) begin
            shift_cnt[i] = '0;
            for (int k = 0; k < RISCV_V_NUM_VALID_OSIZES; k++) begin
                if (alu_if.osize_vector[k]) begin
                    shift_cnt[i] |= alu_if.srca.data[(i >> k) << k][RISCV_V_SHIFT_CNT_WIDTH-1:0]
                                    & cnt_mask;
                end
            end
        end
    end

    // Byte order reversed for left shifts
    for (genvar i = 0; i < RISCV_V_NUM_BYTES_DATA; i++) begin : g_lane_order
        assign data_in[i]  = alu_if.is_left ? alu_if.srcb.data[RISCV_V_NUM_BYTES_DATA-1-i]
                                            : alu_if.srcb.data[i];
        assign lane_cnt[i] = alu_if.is_left ? shift_cnt[RISCV_V_NUM_BYTES_DATA-1-i]
                                            : shift_cnt[i];
        if (i < RISCV_V_NUM_BYTES_DATA-1) begin : g_merge
            assign lane_merge[i] = alu_if.is_left
                                 ? alu_if.srcb.merge[RISCV_V_NUM_BYTES_DATA-2-i]
                                 : alu_if.srcb.merge[i];
        end else begin : g_merge_top
            assign lane_merge[i] = 1'b0;
        end
        assign byte_mux[0][i] = data_in[i];
    end

    // Stage s moves bytes down by 2^s lanes
    for (genvar s = 0; s < RISCV_V_BYTE_SEL_WIDTH; s++) begin : g_stage
        for (genvar i = 0; i < RISCV_V_NUM_BYTES_DATA; i++) begin : g_lane
            Byte_t fill;

            // Sign of the top byte in this aligned group, zero for logical shifts
            assign fill = {BYTE_WIDTH{alu_if.is_arith &
                           byte_mux[s][((i >> s) << s) + (1 << s) - 1][BYTE_WIDTH-1]}};

            if (i + (1 << s) < RISCV_V_NUM_BYTES_DATA) begin : g_move
                assign byte_mux[s+1][i] =
                    !lane_cnt[i][RISCV_V_BIT_SEL_WIDTH+s] ? byte_mux[s][i] :
                    (&lane_merge[i +: (1 << s)])          ? byte_mux[s][i + (1 << s)] :
                                                            fill;
            end else begin : g_edge
                assign byte_mux[s+1][i] = lane_cnt[i][RISCV_V_BIT_SEL_WIDTH+s]
                                        ? fill : byte_mux[s][i];
            end
        end
    end

    // Bit shift within each lane, neighbour lane feeds the vacated bits
    for (genvar i = 0; i < RISCV_V_NUM_BYTES_DATA; i++) begin : g_bit_shift
        if (i < RISCV_V_NUM_BYTES_DATA-1) begin : g_fill
            assign lane_shift_in[i] = byte_mux[RISCV_V_BYTE_SEL_WIDTH][i+1]
                                    & {BYTE_WIDTH{lane_merge[i]}};
        end else begin : g_fill_top
            assign lane_shift_in[i] = '0;
        end

        // Only the top byte of an element takes the sign fill
        assign lane_arith[i] = alu_if.is_arith & ~lane_merge[i];

        shifter #(
            .WIDTH(BYTE_WIDTH)
        ) u_byte_shifter (
            .src         (byte_mux[RISCV_V_BYTE_SEL_WIDTH][i]),
            .shift       (lane_cnt[i][RISCV_V_BIT_SEL_WIDTH-1:0]),
            .shift_left  (alu_if.is_left),
            .shift_arith (lane_arith[i]),
            .shift_in    (lane_shift_in[i]),
            .result      (lane_result[i])
        );

        assign result[i] = alu_if.is_left ? lane_result[RISCV_V_NUM_BYTES_DATA-1-i]
                                          : lane_result[i];
    end

endmodule : riscv_v_shifter

//--- hw/shifter.sv
/*
 * Single-lane shifter
 * Right shift with a shift-in word for cross-lane fill, sign fill,
 * and left shift through bit reversal
 */
`timescale 1ns/1ps

module shifter #(
    parameter int WIDTH = 8
) (
    input  logic [WIDTH-1:0]         src,
    input  logic [$clog2(WIDTH)-1:0] shift,
    input  logic                     shift_left,
    input  logic                     shift_arith,
    input  logic [WIDTH-1:0]         shift_in,
    output logic [WIDTH-1:0]         result
);

    logic [WIDTH-1:0]   src_ord;
    logic [WIDTH-1:0]   fill_ord;
    logic [WIDTH-1:0]   fill_word;
    logic [2*WIDTH-1:0] window;
    logic [WIDTH-1:0]   res_ord;

    // Left shifts run as right shifts on bit-reversed data
    always_comb begin
        for (int b = 0; b < WIDTH; b++) begin
            src_ord[b]  = shift_left ? src[WIDTH-1-b] : src[b];
            fill_ord[b] = shift_left ? shift_in[WIDTH-1-b] : shift_in[b];
        end
    end

    assign fill_word = shift_arith ? {WIDTH{src_ord[WIDTH-1]}} : fill_ord;
    assign window    = {fill_word, src_ord};
    assign res_ord   = window[shift +: WIDTH];

    always_comb begin
        for (int b = 0; b < WIDTH; b++) begin
            result[b] = shift_left ? res_ord[WIDTH-1-b] : res_ord[b];
        end
    end

endmodule : shifter

//--- hw/riscv_v_decode.sv
/*
 * Vector ALU decode stage
 * Registers an operation and expands it into shift flags,
 * element-size vectors and byte merge bits
 */
`timescale 1ns/1ps

module riscv_v_decode
    import riscv_v_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          in_valid,
    input  riscv_v_alu_op_t               op,
    input  osize_t                        osize,
    input  logic [RISCV_V_DATA_WIDTH-1:0] srca,
    input  logic [RISCV_V_DATA_WIDTH-1:0] srcb,
    riscv_v_alu_if.decode                 alu_if
);

    osize_vector_t       osize_vector_d;
    osize_vector_t       greater_d;
    riscv_v_merge_data_t merge_d;

    always_comb begin
        osize_vector_d        = '0;
        osize_vector_d[osize] = 1'b1;
        // Bit k marks an element wider than 8*2^(k-1) bits
        for (int k = 0; k < RISCV_V_NUM_VALID_OSIZES; k++) begin
            greater_d[k] = (osize >= k);
        end
        merge_d = '0;
        case (osize)
            OSIZE_8:  merge_d = 8'b0000_0000;
            OSIZE_16: merge_d = 8'b0101_0101;
            OSIZE_32: merge_d = 8'b0111_0111;
            OSIZE_64: merge_d = 8'b0111_1111;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            alu_if.valid <= 1'b0;
        end else begin
            alu_if.valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        alu_if.op                      <= op;
        alu_if.is_shift                <= (op == VSLL) || (op == VSRL) || (op == VSRA);
        alu_if.is_left                 <= (op == VSLL);
        alu_if.is_arith                <= (op == VSRA);
        alu_if.osize_vector            <= osize_vector_d;
        alu_if.is_greater_osize_vector <= greater_d;
        // Both operands carry the element boundaries
        alu_if.srca                    <= {srca, merge_d};
        alu_if.srcb                    <= {srcb, merge_d};
    end

    // A valid operation always carries exactly one element size
    assert property (@(posedge clk) disable iff (!rst_n)
        alu_if.valid |-> $onehot(alu_if.osize_vector))
        else $error("decode: osize_vector is not one-hot for a valid operation");

endmodule : riscv_v_decode

//--- hw/riscv_v_alu_if.sv
/*
 * Vector ALU decoded-operation bundle
 * Carries the decode stage output to the execution units and result stage
 */
`timescale 1ns/1ps

interface riscv_v_alu_if
    import riscv_v_pkg::*;
();

    logic              valid;
    riscv_v_alu_op_t   op;
    logic              is_shift;
    logic              is_left;
    logic              is_arith;
    osize_vector_t     osize_vector;
    osize_vector_t     is_greater_osize_vector;
    riscv_v_alu_data_t srca;
    riscv_v_alu_data_t srcb;

    modport decode (
        output valid, op, is_shift, is_left, is_arith,
        output osize_vector, is_greater_osize_vector, srca, srcb
    );

    modport shift (input is_left, is_arith, osize_vector, is_greater_osize_vector, srca, srcb);

    modport intu (input op, srca, srcb);

    modport sel (input valid, is_shift);

endinterface : riscv_v_alu_if

//--- hw/riscv_v_pkg.sv
/*
 * Vector ALU package
 * Slice widths, element-size and operation encodings, shared data types
 */
package riscv_v_pkg;

    localparam int RISCV_V_DATA_WIDTH       = 64;
    localparam int BYTE_WIDTH               = 8;
    localparam int RISCV_V_NUM_BYTES_DATA   = RISCV_V_DATA_WIDTH / BYTE_WIDTH;
    localparam int RISCV_V_NUM_VALID_OSIZES = 4;

    // Shift count split into bit-in-byte and whole-byte parts
    localparam int RISCV_V_BIT_SEL_WIDTH   = $clog2(BYTE_WIDTH);
    localparam int RISCV_V_BYTE_SEL_WIDTH  = $clog2(RISCV_V_NUM_BYTES_DATA);
    localparam int RISCV_V_SHIFT_CNT_WIDTH = RISCV_V_BIT_SEL_WIDTH + RISCV_V_BYTE_SEL_WIDTH;

    typedef logic [1:0] osize_t;

    localparam osize_t OSIZE_8  = 2'd0;
    localparam osize_t OSIZE_16 = 2'd1;
    localparam osize_t OSIZE_32 = 2'd2;
    localparam osize_t OSIZE_64 = 2'd3;

    typedef logic [RISCV_V_NUM_VALID_OSIZES-1:0] osize_vector_t;

    typedef enum logic [2:0] {
        VADD = 3'd0,
        VSUB = 3'd1,
        VAND = 3'd2,
        VOR  = 3'd3,
        VXOR = 3'd4,
        VSLL = 3'd5,
        VSRL = 3'd6,
        VSRA = 3'd7
    } riscv_v_alu_op_t;

    typedef logic [BYTE_WIDTH-1:0] Byte_t;
    typedef Byte_t [RISCV_V_NUM_BYTES_DATA-1:0] riscv_v_src_byte_vector_t;

    // Bit i set when byte i and byte i+1 share an element
    typedef logic [RISCV_V_NUM_BYTES_DATA-1:0] riscv_v_merge_data_t;

    typedef logic [RISCV_V_SHIFT_CNT_WIDTH-1:0] riscv_v_shift_cnt_t;

    typedef struct packed {
        riscv_v_src_byte_vector_t data;
        riscv_v_merge_data_t      merge;
    } riscv_v_alu_data_t;

endpackage : riscv_v_pkg
